//--- board_pkg.sv
// ------------------------------
// shared constants, register offsets and watchdog level codes
// import inside each module body; use scoped names in port lists
// ------------------------------
package board_pkg;

    // ------------------------------
    // sizes and fixed words
    // ------------------------------
    localparam int NUM_AXES = 4;                       // amplifier axes on the board
    localparam logic [3:0]  ADDR_MAIN     = 4'h0;      // waddr[15:12] for this block
    localparam logic [31:0] FW_VERSION    = 32'h0000_0008;
    localparam logic [31:0] BOARD_VERSION = 32'h514C_4131;

    // reset values
    localparam logic [15:0] WDOG_PERIOD_RESET = 16'h1680;   // about 30 ms of ticks
    localparam logic [31:0] DEBUG_RESET       = 32'h2000;

    // ------------------------------
    // timing
    // ------------------------------
    localparam int WDOG_TICK_WIDTH = 8;                // tick every 256 sysclk
    localparam logic [15:0] MV_SETTLE_TICKS = 16'd7680; // motor voltage settle time
    localparam logic [15:0] WDOG_LEVEL_1 = 16'h2580;
    localparam logic [15:0] WDOG_LEVEL_2 = 16'h4B00;
    localparam logic [15:0] WDOG_LEVEL_3 = 16'h7080;
    localparam logic [15:0] WDOG_LEVEL_4 = 16'h9600;

    // register offsets, waddr/raddr bits 3..0
    typedef enum logic [3:0] {
        REG_STATUS   = 4'd0,
        REG_PHYCTRL  = 4'd1,
        REG_PHYDATA  = 4'd2,
        REG_TIMEOUT  = 4'd3,
        REG_VERSION  = 4'd4,
        REG_TEMPSNS  = 4'd5,
        REG_DIGIOUT  = 4'd6,
        REG_FVERSION = 4'd7,
        REG_DIGIN    = 4'd10,
        REG_DEBUG    = 4'd15
    } reg_offset_e;

    // watchdog period band, drives the led pattern
    typedef enum logic [2:0] {
        WDOG_DISABLE     = 3'd0,
        WDOG_PHASE_ONE   = 3'd1,
        WDOG_PHASE_TWO   = 3'd2,
        WDOG_PHASE_THREE = 3'd3,
        WDOG_PHASE_FOUR  = 3'd4,
        WDOG_PHASE_FIVE  = 3'd5
    } wdog_level_e;

endpackage

//--- axis_ctrl_if.sv
// ------------------------------
// per-axis control link, one instance per amplifier axis
// ------------------------------
`timescale 1ns/100ps

interface axis_ctrl_if;

    logic cmd_strobe;   // status register write this cycle
    logic cmd_mask;     // wdata[8+i]
    logic cmd_value;    // wdata[i], 1 = enable
    logic pwr_enable;   // board power level before the write
    logic force_off;    // watchdog timeout or safety disable
    logic amp_off;      // axis disable flag

    // register file side
    modport regs (
        output cmd_strobe,
        output cmd_mask,
        output cmd_value,
        output pwr_enable,
        output force_off,
        input  amp_off
    );

    // per-axis flag logic
    modport axis (
        input  cmd_strobe,
        input  cmd_mask,
        input  cmd_value,
        input  pwr_enable,
        input  force_off,
        output amp_off
    );

    modport drain (input amp_off);  // settle stage only reads the flag

endinterface

//--- board_regs.sv
// ------------------------------
// host register file: write decode, masked status bits, read mux
// ------------------------------
`timescale 1ns/100ps

module board_regs (
    input  logic                           sysclk,
    input  logic                           reset,
    // host bus
    input  logic [15:0]                    reg_raddr,
    input  logic [15:0]                    reg_waddr,
    input  logic [31:0]                    reg_wdata,
    input  logic                           reg_wen,
    output logic [31:0]                    reg_rdata,
    // board inputs
    input  logic [3:0]                     board_id,     // rotary switch
    input  logic [15:0]                    temp_sense,
    input  logic [31:0]                    dout,
    input  logic [board_pkg::NUM_AXES-1:0] fault,
    input  logic [board_pkg::NUM_AXES-1:0] safety_amp_disable,
    input  logic [board_pkg::NUM_AXES-1:0] neg_limit,
    input  logic [board_pkg::NUM_AXES-1:0] pos_limit,
    input  logic [board_pkg::NUM_AXES-1:0] home,
    input  logic                           mv_good,
    input  logic                           mv_faultn,    // active low
    input  logic                           safety_fb,
    input  logic                           mv_fb,
    // watchdog feedback
    input  logic                           wdog_timeout,
    input  board_pkg::wdog_level_e         wdog_level,
    // control outputs
    output logic                           pwr_enable,
    output logic                           relay_on,
    output logic                           reboot,
    output logic [15:0]                    phy_ctrl,
    output logic [15:0]                    phy_data,
    output logic [31:0]                    reg_debug,
    output logic [15:0]                    wdog_period,
    output logic                           wdog_led,
    output logic                           powerup_cmd,
    axis_ctrl_if.regs                      ax [board_pkg::NUM_AXES]
);
    import board_pkg::*;

    logic                write_main;
    logic                write_status;
    reg_offset_e         waddr_off;
    reg_offset_e         raddr_off;
    logic [NUM_AXES-1:0] amp_off;         // gathered from the axis links
    logic [NUM_AXES-1:0] amp_enable_cmd;
    logic [31:0]         reg_status;
    logic [31:0]         reg_digin;

    assign waddr_off = reg_offset_e'(reg_waddr[3:0]);
    assign raddr_off = reg_offset_e'(reg_raddr[3:0]);

    // main write: our block, low page only
    assign write_main   = reg_wen && (reg_waddr[15:12] == ADDR_MAIN) && (reg_waddr[7:4] == 4'd0);
    assign write_status = write_main && (waddr_off == REG_STATUS);

    // ------------------------------
    // per-axis links
    // ------------------------------
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        assign ax[i].cmd_strobe = write_status;
        assign ax[i].cmd_mask   = reg_wdata[8+i];
        assign ax[i].cmd_value  = reg_wdata[i];
        assign ax[i].pwr_enable = pwr_enable;                           // level before the write
        assign ax[i].force_off  = wdog_timeout | safety_amp_disable[i];
        assign amp_off[i]       = ax[i].amp_off;
        assign amp_enable_cmd[i] = write_status & reg_wdata[8+i] & reg_wdata[i];
    end

    // host trying to power up board or any axis, clears watchdog
    assign powerup_cmd = (write_status & reg_wdata[19] & reg_wdata[18]) | (|amp_enable_cmd);

    // status word, see register map
    assign reg_status = {
        4'(NUM_AXES), board_id,
        wdog_timeout, mv_good, pwr_enable, relay_on,
        ~mv_faultn, safety_fb, 2'b00,
        fault,
        safety_amp_disable, 4'b0000,
        ~amp_off                      // 1 = axis enabled
    };

    assign reg_digin = {15'd0, mv_fb, dout[3:0], neg_limit, pos_limit, home};

    // ------------------------------
    // control registers
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            pwr_enable  <= 1'b0;
            relay_on    <= 1'b0;
            reboot      <= 1'b0;
            wdog_led    <= 1'b0;
            wdog_period <= WDOG_PERIOD_RESET;
            reg_debug   <= DEBUG_RESET;
        end else begin
            reboot <= write_status & reg_wdata[21] & reg_wdata[20];   // one-cycle pulse
            if (write_status) begin
                if (reg_wdata[19])
                    pwr_enable <= reg_wdata[18];
                if (reg_wdata[17])
                    relay_on <= reg_wdata[16];
            end
            if (write_main && waddr_off == REG_TIMEOUT) begin
                wdog_led    <= reg_wdata[31];
                wdog_period <= reg_wdata[15:0];   // 0 turns the watchdog off
            end
            if (write_main && waddr_off == REG_DEBUG)
                reg_debug <= reg_wdata;
        end
    end

    // phy words and registered read data
    always_ff @(posedge sysclk) begin
        if (write_main) begin
            if (waddr_off == REG_PHYCTRL)
                phy_ctrl <= reg_wdata[15:0];
            if (waddr_off == REG_PHYDATA)
                phy_data <= reg_wdata[15:0];
        end else begin
            case (raddr_off)
                REG_STATUS:   reg_rdata <= reg_status;
                REG_PHYCTRL:  reg_rdata <= {16'd0, phy_ctrl};
                REG_PHYDATA:  reg_rdata <= {16'd0, phy_data};
                // level in 18..16
                REG_TIMEOUT:  reg_rdata <= {wdog_led, 12'd0, wdog_level, wdog_period};
                REG_VERSION:  reg_rdata <= BOARD_VERSION;
                REG_TEMPSNS:  reg_rdata <= {16'd0, temp_sense};
                REG_DIGIOUT:  reg_rdata <= dout;
                REG_FVERSION: reg_rdata <= FW_VERSION;
                REG_DIGIN:    reg_rdata <= reg_digin;
                REG_DEBUG:    reg_rdata <= reg_debug;
                default:      reg_rdata <= 32'd0;       // unmapped offsets
            endcase
        end
    end

endmodule

//--- wdog_timer.sv
// ------------------------------
// host watchdog with tick divider and led period band decode
// ------------------------------
`timescale 1ns/100ps

module wdog_timer (
    input  logic                   sysclk,
    input  logic                   reset,
    input  logic                   reg_wen,       // any host write kicks the dog
    input  logic                   powerup_cmd,
    input  logic [15:0]            wdog_period,
    output logic                   tick,
    output logic                   wdog_timeout,
    output board_pkg::wdog_level_e wdog_level
);
    import board_pkg::*;

    logic [WDOG_TICK_WIDTH-1:0] div_cnt;
    logic [15:0]                wdog_count;   // ticks since last write

    // free-running divider, tick on wrap
    always_ff @(posedge sysclk) begin
        if (reset)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign tick = &div_cnt;

    // ------------------------------
    // counter and sticky timeout
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            wdog_count   <= 16'd0;
            wdog_timeout <= 1'b0;
        end else if (powerup_cmd) begin
            wdog_count   <= 16'd0;     // host is re-enabling, start clean
            wdog_timeout <= 1'b0;
        end else if (reg_wen) begin
            wdog_count <= 16'd0;
        end else if (tick && wdog_period != 16'd0) begin
            if (wdog_count < wdog_period)
                wdog_count <= wdog_count + 1'b1;
            else
                wdog_timeout <= 1'b1;  // holds until power-up
        end
    end

    // period band for led feedback
    always_comb begin
        if (wdog_period == 16'd0)
            wdog_level = WDOG_DISABLE;
        else if (wdog_period <= WDOG_LEVEL_1)
            wdog_level = WDOG_PHASE_ONE;
        else if (wdog_period <= WDOG_LEVEL_2)
            wdog_level = WDOG_PHASE_TWO;
        else if (wdog_period <= WDOG_LEVEL_3)
            wdog_level = WDOG_PHASE_THREE;
        else if (wdog_period <= WDOG_LEVEL_4)
            wdog_level = WDOG_PHASE_FOUR;
        else
            wdog_level = WDOG_PHASE_FIVE;
    end

endmodule

//--- axis_enable.sv
// ------------------------------
// amplifier disable flag for one axis
// masked host enable, forced off by watchdog or safety
// ------------------------------
`timescale 1ns/100ps

module axis_enable (
    input  logic      sysclk,
    input  logic      reset,
    axis_ctrl_if.axis ctl
);

    logic amp_off;   // 1 = amplifier disabled

    always_ff @(posedge sysclk) begin
        if (reset) begin
            amp_off <= 1'b1;                         // all axes start disabled
        end else if (ctl.cmd_strobe) begin
            if (!ctl.pwr_enable)
                amp_off <= 1'b1;                     // no board power, stay off
            else if (ctl.cmd_mask)
                amp_off <= ~ctl.cmd_value;
        end else begin
            amp_off <= amp_off | ctl.force_off;      // sticky until host re-enables
        end
    end

    assign ctl.amp_off = amp_off;

endmodule

//--- power_settle.sv
// ------------------------------
// holds amplifiers off while motor voltage settles,
// then merges with the per-axis flags onto amp_disable
// ------------------------------
`timescale 1ns/100ps

module power_settle (
    input  logic                           sysclk,
    input  logic                           reset,
    input  logic                           tick,
    input  logic                           mv_good,
    output logic [board_pkg::NUM_AXES-1:0] amp_disable,
    axis_ctrl_if.drain                     ax [board_pkg::NUM_AXES]
);
    import board_pkg::*;

    logic [15:0] settle_cnt;
    logic        settle_hold;   // 1 until mv_good held long enough

    always_ff @(posedge sysclk) begin
        if (reset) begin
            settle_cnt  <= 16'd0;
            settle_hold <= 1'b1;
        end else if (!mv_good) begin
            settle_cnt  <= 16'd0;          // voltage lost, start over
            settle_hold <= 1'b1;
        end else if (tick) begin
            if (settle_cnt < MV_SETTLE_TICKS)
                settle_cnt <= settle_cnt + 1'b1;
            else
                settle_hold <= 1'b0;
        end
    end

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_drain
        assign amp_disable[i] = ax[i].amp_off | settle_hold;
    end

endmodule

//--- board_ctrl_top.sv
// ------------------------------
// board register block top: host bus, watchdog, axis enables
// ------------------------------
`timescale 1ns/100ps

module board_ctrl_top (
    input  logic                           sysclk,
    input  logic                           reset,
    // host bus
    input  logic [15:0]                    reg_raddr,
    input  logic [15:0]                    reg_waddr,
    input  logic [31:0]                    reg_wdata,
    input  logic                           reg_wen,
    output logic [31:0]                    reg_rdata,
    // board inputs
    input  logic [3:0]                     board_id,
    input  logic [15:0]                    temp_sense,
    input  logic [31:0]                    dout,
    input  logic [board_pkg::NUM_AXES-1:0] fault,
    input  logic [board_pkg::NUM_AXES-1:0] safety_amp_disable,
    input  logic [board_pkg::NUM_AXES-1:0] neg_limit,
    input  logic [board_pkg::NUM_AXES-1:0] pos_limit,
    input  logic [board_pkg::NUM_AXES-1:0] home,
    input  logic                           mv_good,
    input  logic                           mv_faultn,
    input  logic                           safety_fb,
    input  logic                           mv_fb,
    // board controls
    output logic                           pwr_enable,
    output logic                           relay_on,
    output logic                           reboot,
    output logic [15:0]                    phy_ctrl,
    output logic [15:0]                    phy_data,
    output logic [31:0]                    reg_debug,
    output logic [15:0]                    wdog_period,
    output logic                           wdog_led,
    output logic                           wdog_timeout,
    output board_pkg::wdog_level_e         wdog_level,
    output logic [board_pkg::NUM_AXES-1:0] amp_disable   // to amplifier pins
);
    import board_pkg::*;

    logic powerup_cmd;
    logic tick;

    axis_ctrl_if ax_if [NUM_AXES] ();   // one link per axis

    board_regs u_board_regs (
        .sysclk, .reset,
        .reg_raddr, .reg_waddr, .reg_wdata, .reg_wen, .reg_rdata,
        .board_id, .temp_sense, .dout, .fault, .safety_amp_disable,
        .neg_limit, .pos_limit, .home,
        .mv_good, .mv_faultn, .safety_fb, .mv_fb,
        .wdog_timeout, .wdog_level,
        .pwr_enable, .relay_on, .reboot, .phy_ctrl, .phy_data, .reg_debug,
        .wdog_period, .wdog_led, .powerup_cmd,
        .ax (ax_if)
    );

    wdog_timer u_wdog_timer (
        .sysclk, .reset,
        .reg_wen, .powerup_cmd, .wdog_period,
        .tick, .wdog_timeout, .wdog_level
    );

    // ------------------------------
    // per-axis disable flags
    // ------------------------------
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        axis_enable u_axis_enable (
            .sysclk, .reset,
            .ctl (ax_if[i])
        );
    end

    power_settle u_power_settle (
        .sysclk, .reset,
        .tick, .mv_good,
        .amp_disable,
        .ax (ax_if)
    );

endmodule

//--- tb_clk_gen.sv
// ------------------------------
// testbench clock, 20 ns period, reset held for 3 cycles
// ------------------------------
`timescale 1ns/100ps

module tb_clk_gen (
    output logic sysclk,
    output logic reset
);

    initial sysclk = 1'b0;
    always #10 sysclk = ~sysclk;     // 50 MHz

    initial begin
        reset <= 1'b1;
        repeat (3) @(posedge sysclk);
        reset <= 1'b0;
    end

endmodule

//--- tb_board_ctrl.sv
// ------------------------------
// testbench top: replays board_stimulus.txt against the DUT
// columns are opcode, address, data and expected value, all hex
// ------------------------------
`timescale 1ns/100ps

module tb_board_ctrl;
    import board_pkg::*;

    logic sysclk, reset;
    logic [15:0] reg_raddr, reg_waddr, temp_sense;
    logic [31:0] reg_wdata, reg_rdata, dout, reg_debug;
    logic reg_wen, mv_good, mv_faultn, safety_fb, mv_fb;
    logic [3:0] board_id;
    logic [NUM_AXES-1:0] fault, safety_amp_disable, neg_limit, pos_limit, home;
    logic [NUM_AXES-1:0] amp_disable;
    logic pwr_enable, relay_on, reboot, wdog_led, wdog_timeout;
    logic [15:0] phy_ctrl, phy_data, wdog_period;
    wdog_level_e wdog_level;

    int          fd, code, n_tests, n_fail, cnt;
    integer      seed;
    logic [31:0] op, addr, data, exp_val, rd;
    logic        test_ok, is_test;
    logic        exp_pwr, exp_relay;     // model of the masked status bits

    tb_clk_gen u_clk_gen (.sysclk, .reset);

    board_ctrl_top u_board_ctrl_top (.*);

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_word(input logic [31:0] got, exp, mask, input string what);
        if ((got & mask) !== (exp & mask)) begin
            $display("ERROR @ %0t: %s read %h, expected %h under mask %h",
                     $time, what, got, exp, mask);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_axes(input logic [NUM_AXES-1:0] got, exp);
        if (got !== exp) begin
            $display("ERROR @ %0t: amp_disable is %b, expected %b", $time, got, exp);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_level(input wdog_level_e got, exp);
        if (got !== exp) begin
            $display("ERROR @ %0t: wdog_level is %0d, expected %0d", $time, got, exp);
            test_ok = 1'b0;
        end
    endtask

    // ------------------------------
    // host bus drivers
    // ------------------------------
    task automatic host_write(input logic [3:0] off, input logic [31:0] wd);
        @(posedge sysclk);
        reg_waddr <= {ADDR_MAIN, 8'h00, off};
        reg_wdata <= wd;
        reg_wen   <= 1'b1;
        @(posedge sysclk);          // register takes it here
        reg_wen   <= 1'b0;
    endtask

    task automatic host_read(input logic [3:0] off, output logic [31:0] word);
        @(posedge sysclk);
        reg_raddr <= {ADDR_MAIN, 8'h00, off};
        @(posedge sysclk);          // rdata registered on this edge
        @(negedge sysclk);
        word = reg_rdata;
    endtask

    // control pins right after the capture edge of a write
    task automatic compare_write_outputs(input logic [3:0] off, input logic [31:0] wd);
        logic pulse;
        pulse = wd[21] & wd[20];    // reboot strobe with its mask
        @(negedge sysclk);
        case (off)
            REG_STATUS: begin
                if (wd[19])
                    exp_pwr = wd[18];
                if (wd[17])
                    exp_relay = wd[16];
                check_word({29'd0, reboot, relay_on, pwr_enable},
                           {29'd0, pulse, exp_relay, exp_pwr}, 32'h7, "status pins");
                @(posedge sysclk);
                @(negedge sysclk);
                check_word({31'd0, reboot}, 32'd0, 32'h1, "reboot one cycle later");
            end
            REG_PHYCTRL: check_word({16'd0, phy_ctrl}, wd, 32'h0000_FFFF, "phy_ctrl pins");
            REG_PHYDATA: check_word({16'd0, phy_data}, wd, 32'h0000_FFFF, "phy_data pins");
            REG_TIMEOUT: check_word({wdog_led, 15'd0, wdog_period}, wd, 32'h8000_FFFF,
                                    "watchdog pins");
            REG_DEBUG:   check_word(reg_debug, wd, 32'hFFFF_FFFF, "reg_debug pins");
            default: ;
        endcase
    endtask

    task automatic set_input(input logic [31:0] sel, val);
        @(posedge sysclk);
        case (sel)
            0: mv_good    <= val[0];
            1: temp_sense <= val[15:0];
            2: dout       <= val;
            3: home       <= val[NUM_AXES-1:0];
            4: pos_limit  <= val[NUM_AXES-1:0];
            5: neg_limit  <= val[NUM_AXES-1:0];
            6: mv_fb      <= val[0];
            default: begin
                $display("unknown input selector %0h in stimulus file", sel);
                test_ok = 1'b0;
            end
        endcase
    endtask

    // random timeout words, led bit and period read back as written
    task automatic random_timeout(input logic [31:0] count);
        logic [31:0] d;
        logic [31:0] word;
        for (int i = 0; i < count; i++) begin
            d = $random(seed);
            host_write(REG_TIMEOUT, d);
            host_read(REG_TIMEOUT, word);
            check_word(word, d, 32'h8000_FFFF, "random timeout word");
        end
    endtask

    initial begin
        reg_raddr <= '0;
        reg_waddr <= '0;
        reg_wdata <= '0;
        reg_wen <= 1'b0;
        board_id <= 4'h5;
        temp_sense <= '0;
        dout <= '0;
        fault <= '0;
        safety_amp_disable <= '0;
        neg_limit <= '0;
        pos_limit <= '0;
        home <= '0;
        mv_good <= 1'b0;
        mv_faultn <= 1'b1;       // no motor voltage fault
        safety_fb <= 1'b0;
        mv_fb <= 1'b0;
        seed = 32'hf2f5;
        exp_pwr = 1'b0;          // both off after reset
        exp_relay = 1'b0;
        n_tests = 0;
        n_fail = 0;
        cnt = 0;
        while (reset !== 1'b0 && cnt < 20) begin
            @(posedge sysclk);
            cnt++;
        end
        if (reset !== 1'b0) begin
            $display("reset never released");
            n_fail++;
        end
        fd = $fopen("board_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open board_stimulus.txt");
            n_fail++;
        end else begin
            code = $fscanf(fd, "%h %h %h %h", op, addr, data, exp_val);
            while (code == 4) begin
                test_ok = 1'b1;
                is_test = 1'b1;
                case (op)
                    1: begin
                        host_write(addr[3:0], data);
                        compare_write_outputs(addr[3:0], data);
                        is_test = 1'b0;
                    end
                    2: begin                                // data column is the mask
                        host_read(addr[3:0], rd);
                        check_word(rd, exp_val, data, "register");
                    end
                    3: begin
                        @(posedge sysclk);
                        @(negedge sysclk);
                        check_axes(amp_disable, exp_val[NUM_AXES-1:0]);
                    end
                    4: begin                                // period write, then band
                        host_write(REG_TIMEOUT, data);
                        @(negedge sysclk);
                        check_level(wdog_level, wdog_level_e'(exp_val[2:0]));
                    end
                    5: begin                                // wait for watchdog expiry
                        cnt = 0;
                        while (!wdog_timeout && cnt < data) begin
                            @(negedge sysclk);
                            cnt++;
                        end
                        if (!wdog_timeout) begin
                            $display("watchdog timeout did not rise within %0d cycles", data);
                            test_ok = 1'b0;
                        end
                    end
                    6: begin                                // settle wait, addr is min cycles
                        cnt = 0;
                        while (amp_disable !== exp_val[NUM_AXES-1:0] && cnt < data) begin
                            @(negedge sysclk);
                            cnt++;
                        end
                        if (amp_disable !== exp_val[NUM_AXES-1:0]) begin
                            $display("amp_disable did not reach %h within %0d cycles",
                                     exp_val[NUM_AXES-1:0], data);
                            test_ok = 1'b0;
                        end else if (cnt < addr) begin
                            $display("amp_disable released after only %0d cycles", cnt);
                            test_ok = 1'b0;
                        end
                    end
                    7: begin
                        set_input(addr, data);
                        is_test = 1'b0;
                    end
                    8: random_timeout(data);
                    default: begin
                        $display("unknown opcode %0h in stimulus file", op);
                        test_ok = 1'b0;
                    end
                endcase
                if (is_test || !test_ok) begin
                    n_tests++;
                    if (!test_ok)
                        n_fail++;
                    $display("test %0d (op %0h, addr %0h): %s", n_tests, op, addr,
                             test_ok ? "ok" : "FAILED");
                end
                code = $fscanf(fd, "%h %h %h %h", op, addr, data, exp_val);
            end
            $fclose(fd);
        end
        $display("%0d tests run, %0d failed", n_tests, n_fail);
        if (n_fail == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- sources.f
board_pkg.sv
axis_ctrl_if.sv
board_regs.sv
wdog_timer.sv
axis_enable.sv
power_settle.sv
board_ctrl_top.sv
tb_clk_gen.sv
tb_board_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and check the log

LOG=sim.log

verilator --binary --timing -f sources.f --top-module tb_board_ctrl -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    exit 0
else
    echo "pass line not found in $LOG"
    exit 1
fi

//--- board_stimulus.txt
2 0 FFFFFFFF 45000000
2 3 FFFFFFFF 00011680
2 F FFFFFFFF 00002000
3 0 0 F
1 1 0000BEEF 0
2 1 FFFFFFFF 0000BEEF
1 2 12345678 0
2 2 FFFFFFFF 00005678
1 F CAFEF00D 0
2 F FFFFFFFF CAFEF00D
8 3 4 0
1 3 0 0
2 4 FFFFFFFF 514C4131
2 7 FFFFFFFF 00000008
7 1 00000ABC 0
2 5 FFFFFFFF 00000ABC
7 2 A5A500C3 0
2 6 FFFFFFFF A5A500C3
7 3 1 0
7 4 2 0
7 5 4 0
7 6 1 0
2 A FFFFFFFF 00013421
2 8 FFFFFFFF 0
2 D FFFFFFFF 0
1 0 00000F0F 0
2 0 0020000F 0
1 0 000C0000 0
1 0 00030000 0
1 0 00000505 0
2 0 0030000F 00300005
1 0 0 0
2 0 0030000F 00300005
3 0 0 F
1 3 3 0
5 0 1388 0
2 0 0080000F 00800000
1 0 00000F0F 0
1 3 0 0
2 0 00A0000F 0020000F
4 0 0 0
4 0 2580 1
4 0 2581 2
4 0 4B00 2
4 0 7080 3
4 0 9600 4
4 0 9601 5
4 0 0 0
7 0 1 0
3 0 0 F
6 1DE840 1E8480 0
7 0 0 0
3 0 0 F
